//--- sim.f
cpu_pkg.sv
vector_loader.sv
fetch_sequencer.sv
alu8.sv
accum_regs.sv
core6809.sv
core6809_props.sv
core6809_checker.sv
tb_core6809.sv

//--- tb_core6809.sv
//--------------------------------------------------------------------------
// Testbench for the reduced 6809-style core
// Program memory is random from a fixed seed
// Vector at FFFE points to 0100
// Run length is a fixed instruction count counted by the checker's model
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_core6809;
  import cpu_pkg::*;

  localparam int NUM_INSTR   = 2000;
  localparam int CLK_PERIOD  = 4;
  // Worst case three cycles per instruction plus reset and vector fetch
  localparam int WATCHDOG_NS = 3 * NUM_INSTR * CLK_PERIOD + 200;

  // Kept opcodes then a few bytes that decode as no-ops
  localparam logic [7:0] OPCODE_POOL [0:27] = '{
    8'h43, 8'h44, 8'h46, 8'h47, 8'h48, 8'h49, 8'h4C, 8'h4F,
    8'h53, 8'h54, 8'h56, 8'h57, 8'h58, 8'h59, 8'h5C, 8'h5F,
    8'h86, 8'hC6, 8'h20, 8'h21, 8'h24, 8'h25, 8'h26, 8'h27,
    8'h12, 8'h3D, 8'h4A, 8'h8B
  };

  // Starts low with no edge at time 0
  logic        clk = 1'b0;
  logic        reset_b;
  logic [7:0]  data_in;
  wire  [15:0] addr;
  wire  [7:0]  a_reg;
  wire  [7:0]  b_reg;
  wire  [7:0]  cc_reg;
  int          instr_count;
  int          addr_errors;
  int          reg_errors;
  int          seed;

  // Program memory shared with the checker
  logic [7:0] mem [0:65535];

  // Opcodes back to back from 0000 with random operand bytes
  task automatic fill_memory;
    int         i;
    logic [7:0] op;
    i = 0;
    while (i < 32'hFFFE) begin
      op = OPCODE_POOL[$unsigned($random(seed)) % 28];
      mem[i] = op;
      i++;
      if ((op[7:4] == MODE_BRANCH || op == 8'h86 || op == 8'hC6) && i < 32'hFFFE) begin
        mem[i] = $random(seed);
        i++;
      end
    end
    // Big-endian reset vector
    mem[16'hFFFE] = 8'h01;
    mem[16'hFFFF] = 8'h00;
  endtask

  core6809 u_dut (
    .clk     (clk),
    .reset_b (reset_b),
    .addr    (addr),
    .data_in (data_in),
    .a_reg   (a_reg),
    .b_reg   (b_reg),
    .cc_reg  (cc_reg)
  );

  core6809_checker u_checker (
    .clk         (clk),
    .reset_b     (reset_b),
    .addr        (addr),
    .a_reg       (a_reg),
    .b_reg       (b_reg),
    .cc_reg      (cc_reg),
    .instr_count (instr_count),
    .addr_errors (addr_errors),
    .reg_errors  (reg_errors)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Same-cycle memory answers for the address of this cycle
  always @(negedge clk) begin
    data_in <= mem[addr];
  end

  //------------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------------
  initial begin
    reset_b = 1'b0;
    data_in = 8'h00;
    seed    = 32'h0842e838;
    fill_memory();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;
    wait (instr_count >= NUM_INSTR);
    // Let the last negedge check land first
    repeat (2) @(posedge clk);
    $display("Errors: addr %0d, register %0d, assertion %0d after %0d instructions",
             addr_errors, reg_errors, u_dut.u_fetch_sequencer.u_props.fail_count,
             instr_count);
    if (addr_errors == 0 && reg_errors == 0 &&
        u_dut.u_fetch_sequencer.u_props.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d instructions finished within %0d ns",
             instr_count, NUM_INSTR, WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- core6809_checker.sv
//--------------------------------------------------------------------------
// Instruction-level model of the reduced core, stepped once per clock
// Reads program memory from tb_core6809.mem by hierarchy
// Compares addr, A, B and CC on every falling edge
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module core6809_checker (
  input  wire                       clk,
  input  wire                       reset_b,
  input  wire [cpu_pkg::ADDR_W-1:0] addr,
  input  wire [7:0]                 a_reg,
  input  wire [7:0]                 b_reg,
  input  wire [7:0]                 cc_reg,
  output int                        instr_count,
  output int                        addr_errors,
  output int                        reg_errors
);
  import cpu_pkg::*;

  // Model phases
  localparam int P_VEC_HI  = 0;
  localparam int P_VEC_LO  = 1;
  localparam int P_FETCH   = 2;
  localparam int P_IR      = 3;
  localparam int P_OPERAND = 4;

  int          phase;
  logic [15:0] pc;
  logic [7:0]  vec_hi;
  logic [7:0]  ir;
  logic [7:0]  opnd;
  logic [7:0]  a_m;
  logic [7:0]  b_m;
  logic [7:0]  cc_m;

  //------------------------------------------------------------------------
  // Decode helpers
  //------------------------------------------------------------------------
  function automatic logic is_inherent(input logic [7:0] op);
    logic kept_op;
    kept_op = op[3:0] inside {OP_COM, OP_LSR, OP_ROR, OP_ASR, OP_ASL, OP_ROL, OP_INC,
                              OP_CLR};
    return (op[7:4] == MODE_INH_A || op[7:4] == MODE_INH_B) && kept_op;
  endfunction

  function automatic logic is_load(input logic [7:0] op);
    return op == {MODE_IMM_A, OP_LD} || op == {MODE_IMM_B, OP_LD};
  endfunction

  function automatic logic is_branch(input logic [7:0] op);
    return op[7:4] == MODE_BRANCH &&
           op[3:0] inside {BR_BRA, BR_BRN, BR_BCC, BR_BCS, BR_BNE, BR_BEQ};
  endfunction

  // B side for 5x and Cx
  function automatic logic uses_b(input logic [7:0] op);
    return op[7:4] == MODE_INH_B || op[7:4] == MODE_IMM_B;
  endfunction

  function automatic logic branch_taken(input logic [7:0] op, input logic [7:0] cc);
    case (op[3:0])
      BR_BRA:  return 1'b1;
      BR_BCC:  return !cc[CC_C];
      BR_BCS:  return cc[CC_C];
      BR_BNE:  return !cc[CC_Z];
      BR_BEQ:  return cc[CC_Z];
      default: return 1'b0;
    endcase
  endfunction

  // Returns {cc, result} per the operation table
  function automatic logic [15:0] apply_op(input logic [7:0] op, input logic [7:0] v,
                                           input logic [7:0] cc_in);
    logic [7:0] r;
    logic [7:0] f;
    r = v;
    f = cc_in;
    if (is_load(op)) begin
      f[CC_V] = 1'b0;
    end else begin
      case (op[3:0])
        OP_CLR: begin
          r       = 8'h00;
          f[CC_V] = 1'b0;
          f[CC_C] = 1'b0;
        end
        OP_INC: begin
          r       = v + 8'h01;
          f[CC_V] = (v == 8'h7F);
        end
        OP_COM: begin
          r       = ~v;
          f[CC_V] = 1'b0;
          f[CC_C] = 1'b1;
        end
        OP_ASL, OP_ROL: begin
          r       = {v[6:0], (op[3:0] == OP_ROL) ? cc_in[CC_C] : 1'b0};
          f[CC_C] = v[7];
          f[CC_V] = v[7] ^ v[6];
        end
        // Right shifts, V untouched
        OP_LSR: begin
          r       = {1'b0, v[7:1]};
          f[CC_C] = v[0];
        end
        OP_ASR: begin
          r       = {v[7], v[7:1]};
          f[CC_C] = v[0];
        end
        OP_ROR: begin
          r       = {cc_in[CC_C], v[7:1]};
          f[CC_C] = v[0];
        end
        default: r = v;
      endcase
    end
    f[CC_N] = r[7];
    f[CC_Z] = (r == 8'h00);
    return {f, r};
  endfunction

  task automatic run_op(input logic [7:0] op, input logic [7:0] src);
    logic [15:0] out;
    out  = apply_op(op, src, cc_m);
    cc_m = out[15:8];
    if (uses_b(op)) begin
      b_m = out[7:0];
    end else begin
      a_m = out[7:0];
    end
  endtask

  // Instruction done, next opcode read at pc
  task automatic fetch_next;
    ir    = tb_core6809.mem[pc];
    pc    = pc + 16'h0001;
    phase = P_IR;
    instr_count++;
  endtask

  //------------------------------------------------------------------------
  // Model step
  //------------------------------------------------------------------------
  always @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      phase       = P_VEC_HI;
      pc          = 16'h0000;
      a_m         = 8'h00;
      b_m         = 8'h00;
      cc_m        = CC_RESET;
      instr_count = 0;
    end else begin
      case (phase)
        P_VEC_HI: begin
          vec_hi = tb_core6809.mem[RESET_VECTOR_ADDR];
          phase  = P_VEC_LO;
        end
        P_VEC_LO: begin
          pc    = {vec_hi, tb_core6809.mem[RESET_VECTOR_ADDR + 16'h0001]};
          phase = P_FETCH;
        end
        P_FETCH: begin
          ir    = tb_core6809.mem[pc];
          pc    = pc + 16'h0001;
          phase = P_IR;
        end
        P_IR: begin
          if (is_load(ir) || is_branch(ir)) begin
            opnd  = tb_core6809.mem[pc];
            pc    = pc + 16'h0001;
            phase = P_OPERAND;
          end else begin
            // Unknown bytes fall through as no-ops
            if (is_inherent(ir)) begin
              run_op(ir, uses_b(ir) ? b_m : a_m);
            end
            fetch_next();
          end
        end
        default: begin
          if (is_load(ir)) begin
            run_op(ir, opnd);
          end
          if (is_branch(ir) && branch_taken(ir, cc_m)) begin
            // Target relative to the byte after the offset
            pc    = pc + {{8{opnd[7]}}, opnd};
            phase = P_FETCH;
            instr_count++;
          end else begin
            fetch_next();
          end
        end
      endcase
    end
  end

  //------------------------------------------------------------------------
  // Compare
  //------------------------------------------------------------------------
  initial begin
    addr_errors = 0;
    reg_errors  = 0;
  end

  always @(negedge clk) begin
    logic [15:0] exp_addr;
    case (phase)
      P_VEC_HI: exp_addr = RESET_VECTOR_ADDR;
      P_VEC_LO: exp_addr = RESET_VECTOR_ADDR + 16'h0001;
      default:  exp_addr = pc;
    endcase
    if (addr !== exp_addr) begin
      addr_errors++;
      $display("ERROR @ %0t: addr %h, expected %h (opcode %h)", $time, addr, exp_addr, ir);
    end
    if (a_reg !== a_m || b_reg !== b_m || cc_reg !== cc_m) begin
      reg_errors++;
      $display("ERROR @ %0t: A/B/CC %h/%h/%h, expected %h/%h/%h (opcode %h)",
               $time, a_reg, b_reg, cc_reg, a_m, b_m, cc_m, ir);
    end
  end

endmodule

`default_nettype wire

//--- core6809_props.sv
//--------------------------------------------------------------------------
// Concurrent checks on the fetch FSM, bound into fetch_sequencer
// fail_count is read by the testbench at the end of the run
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module core6809_props (
  input wire       clk,
  input wire       reset_b,
  input wire [2:0] state,
  input wire       busy,
  input wire       exec_inh,
  input wire       exec_imm
);
  int fail_count = 0;

  // Fetch state stays one-hot
  state_onehot: assert property (@(posedge clk) disable iff (!reset_b) $onehot(state))
    else begin
      fail_count++;
      $error("fetch state %b is not one-hot", state);
    end

  // Nothing runs while the vector loader owns the bus
  no_exec_busy: assert property (@(posedge clk) disable iff (!reset_b)
                                 !(busy && (exec_inh || exec_imm)))
    else begin
      fail_count++;
      $error("execute strobe active while vector loader is busy");
    end

  strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_b)
                                      !(exec_inh && exec_imm))
    else begin
      fail_count++;
      $error("exec_inh and exec_imm active together");
    end

endmodule

bind fetch_sequencer core6809_props u_props (
  .clk      (clk),
  .reset_b  (reset_b),
  .state    (state),
  .busy     (busy),
  .exec_inh (exec_inh),
  .exec_imm (exec_imm)
);

`default_nettype wire

//--- core6809.sv
//--------------------------------------------------------------------------
// Reduced 6809-style core, read-only bus
// Memory must return data_in for addr within the same cycle
// A, B and CC come out as status ports since there is no write path
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module core6809 (
  input  wire                       clk,
  input  wire                       reset_b,
  output wire [cpu_pkg::ADDR_W-1:0] addr,
  input  wire [cpu_pkg::DATA_W-1:0] data_in,
  output wire [7:0]                 a_reg,
  output wire [7:0]                 b_reg,
  output wire [7:0]                 cc_reg
);
  import cpu_pkg::*;

  // Vector loader to sequencer
  wire              busy;
  wire [ADDR_W-1:0] vector_addr;
  wire              vector_valid;
  wire [ADDR_W-1:0] vector;

  // Sequencer to datapath
  opcode_u          opcode;
  wire [DATA_W-1:0] operand;
  wire              exec_inh;
  wire              exec_imm;

  // ALU hookup
  wire [DATA_W-1:0] alu_src;
  wire [DATA_W-1:0] alu_result;
  wire [7:0]        cc_next;

  //------------------------------------------------------------------------
  // Bus side
  //------------------------------------------------------------------------
  vector_loader u_vector_loader (
    .clk          (clk),
    .reset_b      (reset_b),
    .data_in      (data_in),
    .busy         (busy),
    .vector_addr  (vector_addr),
    .vector_valid (vector_valid),
    .vector       (vector)
  );

  // CC feeds back for the branch test
  fetch_sequencer u_fetch_sequencer (
    .clk          (clk),
    .reset_b      (reset_b),
    .data_in      (data_in),
    .busy         (busy),
    .vector_addr  (vector_addr),
    .vector_valid (vector_valid),
    .vector       (vector),
    .cc           (cc_reg),
    .addr         (addr),
    .opcode       (opcode),
    .operand      (operand),
    .exec_inh     (exec_inh),
    .exec_imm     (exec_imm)
  );

  //------------------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------------------
  alu8 u_alu8 (
    .opcode  (opcode),
    .src     (alu_src),
    .cc      (cc_reg),
    .result  (alu_result),
    .cc_next (cc_next)
  );

  accum_regs u_accum_regs (
    .clk      (clk),
    .reset_b  (reset_b),
    .opcode   (opcode),
    .operand  (operand),
    .exec_inh (exec_inh),
    .exec_imm (exec_imm),
    .result   (alu_result),
    .cc_next  (cc_next),
    .alu_src  (alu_src),
    .a        (a_reg),
    .b        (b_reg),
    .cc       (cc_reg)
  );

endmodule

`default_nettype wire

//--- accum_regs.sv
//--------------------------------------------------------------------------
// A, B and CC registers with ALU source select
// Written only on an execute strobe, so branches and no-ops hold state
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module accum_regs (
  input  wire                        clk,
  input  wire                        reset_b,
  input  cpu_pkg::opcode_u           opcode,
  input  wire  [cpu_pkg::DATA_W-1:0] operand,
  input  wire                        exec_inh,
  input  wire                        exec_imm,
  input  wire  [cpu_pkg::DATA_W-1:0] result,
  input  wire  [7:0]                 cc_next,
  output logic [cpu_pkg::DATA_W-1:0] alu_src,
  output logic [cpu_pkg::DATA_W-1:0] a,
  output logic [cpu_pkg::DATA_W-1:0] b,
  output logic [7:0]                 cc
);
  import cpu_pkg::*;

  logic src_imm;
  logic dest_b;
  logic write_en;

  // Immediate modes feed the operand, inherent feed the accumulator
  assign src_imm  = opcode.f.mode == MODE_IMM_A || opcode.f.mode == MODE_IMM_B;
  // B side for modes 5 and C, A otherwise
  assign dest_b   = opcode.f.mode == MODE_INH_B || opcode.f.mode == MODE_IMM_B;
  assign write_en = exec_inh | exec_imm;

  always_comb begin
    if (src_imm) begin
      alu_src = operand;
    end else if (dest_b) begin
      alu_src = b;
    end else begin
      alu_src = a;
    end
  end

  // Result lands at the edge ending the strobed cycle
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a  <= '0;
      b  <= '0;
      cc <= CC_RESET;
    end else if (write_en) begin
      if (dest_b) begin
        b <= result;
      end else begin
        a <= result;
      end
      cc <= cc_next;
    end
  end

endmodule

`default_nettype wire

//--- alu8.sv
//--------------------------------------------------------------------------
// 8-bit ALU, shifts, rotates, COM, INC, CLR and load pass-through
// No add, subtract or half carry; H, E, F and I pass through
// Unknown ops return src and cc untouched
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module alu8 (
  input  cpu_pkg::opcode_u           opcode,
  input  wire  [cpu_pkg::DATA_W-1:0] src,
  input  wire  [7:0]                 cc,
  output logic [cpu_pkg::DATA_W-1:0] result,
  output logic [7:0]                 cc_next
);
  import cpu_pkg::*;

  logic is_ld;
  logic known;
  logic flag_v;
  logic flag_c;

  // Modes 8 and C are loads whatever the op nibble
  assign is_ld = opcode.f.mode == MODE_IMM_A || opcode.f.mode == MODE_IMM_B;

  //------------------------------------------------------------------------
  // Result, V and C
  //------------------------------------------------------------------------
  always_comb begin
    result = src;
    flag_v = cc[CC_V];
    flag_c = cc[CC_C];
    known  = 1'b1;
    if (is_ld) begin
      // Load clears V, keeps C
      flag_v = 1'b0;
    end else begin
      case (opcode.f.op)
        OP_CLR: begin
          result = '0;
          flag_v = 1'b0;
          flag_c = 1'b0;
        end
        OP_INC: begin
          result = src + 1'b1;
          // Signed overflow only from 7F
          flag_v = src == 8'h7F;
        end
        OP_COM: begin
          result = ~src;
          flag_v = 1'b0;
          flag_c = 1'b1;
        end
        OP_ASL: begin
          result = {src[6:0], 1'b0};
          flag_c = src[7];
          flag_v = src[7] ^ src[6];
        end
        OP_ROL: begin
          result = {src[6:0], cc[CC_C]};
          flag_c = src[7];
          flag_v = src[7] ^ src[6];
        end
        // Right shifts leave V alone
        OP_LSR: begin
          result = {1'b0, src[7:1]};
          flag_c = src[0];
        end
        OP_ASR: begin
          result = {src[7], src[7:1]};
          flag_c = src[0];
        end
        OP_ROR: begin
          result = {cc[CC_C], src[7:1]};
          flag_c = src[0];
        end
        default: known = 1'b0;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // Flags
  //------------------------------------------------------------------------
  // N from bit 7 covers LSR too, its top bit is always 0
  always_comb begin
    cc_next = cc;
    if (known) begin
      cc_next[CC_N] = result[7];
      cc_next[CC_Z] = result == '0;
      cc_next[CC_V] = flag_v;
      cc_next[CC_C] = flag_c;
    end
  end

endmodule

`default_nettype wire

//--- fetch_sequencer.sv
//--------------------------------------------------------------------------
// Fetch FSM, PC and address mux for the reduced core
// Unknown opcodes run as one-byte no-ops
// A taken branch spends one extra cycle fetching at the target
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetch_sequencer (
  input  wire                        clk,
  input  wire                        reset_b,
  input  wire  [cpu_pkg::DATA_W-1:0] data_in,
  input  wire                        busy,
  input  wire  [cpu_pkg::ADDR_W-1:0] vector_addr,
  input  wire                        vector_valid,
  input  wire  [cpu_pkg::ADDR_W-1:0] vector,
  input  wire  [7:0]                 cc,
  output logic [cpu_pkg::ADDR_W-1:0] addr,
  output cpu_pkg::opcode_u           opcode,
  output logic [cpu_pkg::DATA_W-1:0] operand,
  output logic                       exec_inh,
  output logic                       exec_imm
);
  import cpu_pkg::*;

  logic [2:0]        state;
  logic [2:0]        state_next;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;
  logic [ADDR_W-1:0] pc_inc;
  logic [ADDR_W-1:0] pc_branch;
  logic              in_ir;
  logic              in_operand;
  logic              is_inh;
  logic              is_imm;
  logic              is_branch;
  logic              take_branch;
  logic              needs_operand;
  logic              branch_go;

  //------------------------------------------------------------------------
  // Decode
  //------------------------------------------------------------------------
  // Inherent A/B, kept ops only
  always_comb begin
    is_inh = 1'b0;
    if (opcode.f.mode == MODE_INH_A || opcode.f.mode == MODE_INH_B) begin
      case (opcode.f.op)
        OP_COM, OP_LSR, OP_ROR, OP_ASR: is_inh = 1'b1;
        OP_ASL, OP_ROL, OP_INC, OP_CLR: is_inh = 1'b1;
        default:                        is_inh = 1'b0;
      endcase
    end
  end

  assign is_imm = (opcode.f.mode == MODE_IMM_A || opcode.f.mode == MODE_IMM_B)
                  && opcode.f.op == OP_LD;

  // Branch condition from current C and Z
  always_comb begin
    is_branch   = 1'b0;
    take_branch = 1'b0;
    if (opcode.f.mode == MODE_BRANCH) begin
      is_branch = 1'b1;
      case (opcode.f.op)
        BR_BRA:  take_branch = 1'b1;
        BR_BRN:  take_branch = 1'b0;
        BR_BCC:  take_branch = !cc[CC_C];
        BR_BCS:  take_branch = cc[CC_C];
        BR_BNE:  take_branch = !cc[CC_Z];
        BR_BEQ:  take_branch = cc[CC_Z];
        default: is_branch = 1'b0;
      endcase
    end
  end

  assign needs_operand = is_imm | is_branch;
  assign in_ir         = state == ST_IR;
  assign in_operand    = state == ST_OPERAND;
  assign branch_go     = in_operand & is_branch & take_branch;

  //------------------------------------------------------------------------
  // Next state and PC
  //------------------------------------------------------------------------
  assign pc_inc    = pc + 1'b1;
  // PC already points past the offset byte here
  assign pc_branch = pc + {{(ADDR_W-DATA_W){operand[DATA_W-1]}}, operand};

  always_comb begin
    state_next = state;
    pc_next    = pc;
    case (state)
      ST_WAIT: begin
        if (vector_valid) begin
          pc_next = vector;
        end else if (!busy) begin
          pc_next    = pc_inc;
          state_next = ST_IR;
        end
      end
      ST_IR: begin
        // Either the operand or the next opcode is read here
        pc_next = pc_inc;
        if (needs_operand) begin
          state_next = ST_OPERAND;
        end
      end
      ST_OPERAND: begin
        if (branch_go) begin
          pc_next    = pc_branch;
          state_next = ST_WAIT;
        end else begin
          pc_next    = pc_inc;
          state_next = ST_IR;
        end
      end
      default: state_next = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= ST_WAIT;
      pc    <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
    end
  end

  // Every entry into ST_IR brings in a fresh opcode
  always_ff @(posedge clk) begin
    if (state_next == ST_IR) begin
      opcode.raw <= data_in;
    end
    if (in_ir && needs_operand) begin
      operand <= data_in;
    end
  end

  //------------------------------------------------------------------------
  // Outputs
  //------------------------------------------------------------------------
  assign addr     = busy ? vector_addr : pc;
  assign exec_inh = in_ir & is_inh;
  assign exec_imm = in_operand & is_imm;

endmodule

`default_nettype wire

//--- vector_loader.sv
//--------------------------------------------------------------------------
// Reset vector fetch, two reads at FFFE and FFFF then idle until reset
// Owns the address bus while busy is high
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module vector_loader (
  input  wire                        clk,
  input  wire                        reset_b,
  input  wire  [cpu_pkg::DATA_W-1:0] data_in,
  output logic                       busy,
  output logic [cpu_pkg::ADDR_W-1:0] vector_addr,
  output logic                       vector_valid,
  output logic [cpu_pkg::ADDR_W-1:0] vector
);
  import cpu_pkg::*;

  // One flag per byte read, high byte first
  logic              rd_hi;
  logic              rd_lo;
  logic [DATA_W-1:0] hi_byte;

  // Sequence hi -> lo -> idle, address steps once
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      rd_hi       <= 1'b1;
      rd_lo       <= 1'b0;
      vector_addr <= RESET_VECTOR_ADDR;
    end else begin
      rd_hi <= 1'b0;
      rd_lo <= rd_hi;
      if (rd_hi) begin
        vector_addr <= vector_addr + 1'b1;
      end
    end
  end

  // High byte held for the low read
  always_ff @(posedge clk) begin
    if (rd_hi) begin
      hi_byte <= data_in;
    end
  end

  assign busy         = rd_hi | rd_lo;
  // Low byte comes straight off the bus
  assign vector_valid = rd_lo;
  assign vector       = {hi_byte, data_in};

endmodule

`default_nettype wire

//--- cpu_pkg.sv
//--------------------------------------------------------------------------
// Shared constants and the opcode type for the reduced 6809-style core
// Only inherent A/B ops, LDA/LDB immediate and six short branches decode
// E, F and I of CC keep their reset value for good
//--------------------------------------------------------------------------
`default_nettype none

package cpu_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // Big-endian reset vector, high byte at the lower address
  localparam logic [ADDR_W-1:0] RESET_VECTOR_ADDR = 16'hFFFE;

  // CC after reset: E, F and I set
  localparam logic [7:0] CC_RESET = 8'hD0;

  // CC bit positions
  localparam int CC_C = 0;
  localparam int CC_V = 1;
  localparam int CC_Z = 2;
  localparam int CC_N = 3;
  localparam int CC_H = 5;

  // Opcode high nibble, addressing mode
  localparam logic [3:0] MODE_BRANCH = 4'h2;
  localparam logic [3:0] MODE_INH_A  = 4'h4;
  localparam logic [3:0] MODE_INH_B  = 4'h5;
  localparam logic [3:0] MODE_IMM_A  = 4'h8;
  localparam logic [3:0] MODE_IMM_B  = 4'hC;

  // Opcode low nibble, ALU operation
  // OP_LD aliases OP_ROR; the mode nibble tells them apart
  localparam logic [3:0] OP_COM = 4'h3;
  localparam logic [3:0] OP_LSR = 4'h4;
  localparam logic [3:0] OP_ROR = 4'h6;
  localparam logic [3:0] OP_ASR = 4'h7;
  localparam logic [3:0] OP_ASL = 4'h8;
  localparam logic [3:0] OP_ROL = 4'h9;
  localparam logic [3:0] OP_INC = 4'hC;
  localparam logic [3:0] OP_CLR = 4'hF;
  localparam logic [3:0] OP_LD  = 4'h6;

  // Short branch low nibbles
  localparam logic [3:0] BR_BRA = 4'h0;
  localparam logic [3:0] BR_BRN = 4'h1;
  localparam logic [3:0] BR_BCC = 4'h4;
  localparam logic [3:0] BR_BCS = 4'h5;
  localparam logic [3:0] BR_BNE = 4'h6;
  localparam logic [3:0] BR_BEQ = 4'h7;

  // One-hot fetch states
  localparam logic [2:0] ST_WAIT    = 3'b001;
  localparam logic [2:0] ST_IR      = 3'b010;
  localparam logic [2:0] ST_OPERAND = 3'b100;

  // Opcode split into mode and operation nibbles
  typedef struct packed {
    logic [3:0] mode;
    logic [3:0] op;
  } opcode_fields_t;

  // Whole byte from the bus, nibbles for decode
  typedef union packed {
    logic [DATA_W-1:0] raw;
    opcode_fields_t    f;
  } opcode_u;

endpackage

`default_nettype wire
